// File: hdl/mmio_pkg.sv
package mmio_pkg;

    // basic widths
    typedef logic [31:0] word_t;     // cpu data or address word
    typedef logic [4:0]  reg_addr_t; // index into the external register bank
    typedef logic [1:0]  rwi_t;      // cpu request code

    // request codes as driven by the cpu
    localparam rwi_t RWI_IDLE  = 2'b00;
    localparam rwi_t RWI_WRITE = 2'b01;
    localparam rwi_t RWI_READ  = 2'b10;
    localparam rwi_t RWI_FETCH = 2'b11;

    // inclusive upper bound of each region, regions follow each other from 0
    localparam word_t FETCH_TOP = 32'd1024; // instruction fetches
    localparam word_t REG_TOP   = 32'd1056; // external register reads
    localparam word_t DMEM_TOP  = 32'd1792; // data reads and writes
    localparam word_t TFT_TOP   = 32'd2047; // posted display writes

    // page prefix sitting above addr[23:0] on the memory bus
    localparam logic [7:0] BUS_PAGE = 8'h33;

    // Initial memory content. Word i holds i * 0x01010101, kept to 32 bits,
    // so every word of a fresh memory has a known and distinct value.
    function automatic word_t init_word(input int unsigned idx);
        word_t w;
        w = word_t'(idx * 32'h0101_0101); // upper bits of the product drop
        return w;
    endfunction

endpackage

// File: hdl/mmio_decoder.sv
`timescale 1ns/1ps

module mmio_decoder (
    // cpu side
    input  mmio_pkg::rwi_t      rwi,        // request code, held while busy
    input  mmio_pkg::word_t     addr,       // word address
    input  mmio_pkg::word_t     wdata,      // write data
    output logic                busy,       // hold the request
    output mmio_pkg::word_t     rdata,      // read data back to cpu
    output mmio_pkg::word_t     instr,      // fetched instruction
    // bus manager
    input  logic                bus_busy,
    input  mmio_pkg::word_t     bus_rdata,
    output logic                bus_read,
    output logic                bus_write,
    output mmio_pkg::word_t     bus_addr,
    output mmio_pkg::word_t     bus_wdata,
    // external register bank
    input  mmio_pkg::word_t     reg_data,
    input  logic                reg_ack,
    input  logic                chip_sel,   // low right after a pin update
    output logic                reg_read,
    output mmio_pkg::reg_addr_t reg_addr,
    // tft spi writer
    input  logic                tft_busy,
    output logic                tft_write,
    output logic [7:0]          tft_addr,
    output mmio_pkg::word_t     tft_data
);
    import mmio_pkg::*;

    logic in_fetch; // 0 .. FETCH_TOP
    logic in_reg;   // FETCH_TOP+1 .. REG_TOP
    logic in_dmem;  // REG_TOP+1 .. DMEM_TOP
    logic in_tft;   // DMEM_TOP+1 .. TFT_TOP

    // region compare, anything above TFT_TOP hits nothing
    assign in_fetch = (addr <= FETCH_TOP);
    assign in_reg   = (addr > FETCH_TOP) && (addr <= REG_TOP);
    assign in_dmem  = (addr > REG_TOP)   && (addr <= DMEM_TOP);
    assign in_tft   = (addr > DMEM_TOP)  && (addr <= TFT_TOP);

    always_comb begin
        // all idle unless a region claims the request
        busy      = 1'b0;
        rdata     = '0;
        instr     = '0;
        bus_read  = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        reg_read  = 1'b0;
        reg_addr  = '0;
        tft_write = 1'b0;
        tft_addr  = '0;
        tft_data  = '0;

        if (in_fetch && rwi == RWI_FETCH) begin
            bus_read = 1'b1;                         // fetch is a plain bus read
            bus_addr = {BUS_PAGE, addr[23:0]};
            instr    = bus_rdata;                    // valid in manager done cycle
            busy     = bus_busy;
        end else if (in_dmem && rwi == RWI_READ) begin
            bus_read = 1'b1;
            bus_addr = {BUS_PAGE, addr[23:0]};
            rdata    = bus_rdata;
            busy     = bus_busy;
        end else if (in_dmem && rwi == RWI_WRITE) begin
            bus_write = 1'b1;
            bus_addr  = {BUS_PAGE, addr[23:0]};
            bus_wdata = wdata;
            busy      = bus_busy;
        end else if (in_reg && rwi == RWI_READ) begin
            reg_read = chip_sel;                     // no read while the bank updates
            reg_addr = addr[4:0];
            rdata    = reg_data;
            // done only on an ack that lands while chip select is back up
            busy     = !(reg_ack && chip_sel);
        end else if (in_tft && rwi == RWI_WRITE) begin
            tft_write = 1'b1;                        // posted, taken when writer is free
            tft_addr  = addr[7:0];
            tft_data  = wdata;
            busy      = tft_busy;
        end
        // other combinations are dropped, they finish at once with rdata zero
    end

endmodule

// File: hdl/wb_manager.sv
`timescale 1ns/1ps

module wb_manager (
    input  logic            clk,
    input  logic            arst_n,
    // decoder side
    input  logic            bus_read,
    input  logic            bus_write,
    input  mmio_pkg::word_t bus_addr,
    input  mmio_pkg::word_t bus_wdata,
    output logic            bus_busy,
    output mmio_pkg::word_t bus_rdata,  // held word from the last read
    // bus side
    output logic            cyc,
    output logic            stb,
    output logic            we,
    output mmio_pkg::word_t adr,
    output mmio_pkg::word_t dat_w,
    input  logic            ack,
    input  mmio_pkg::word_t dat_r
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,  // waiting for a strobe from the decoder
        ST_CYCLE, // bus cycle open, waiting on ack
        ST_DONE   // result ready, cpu completes here
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   req;   // decoder wants a bus access
    logic   start; // request taken in idle

    assign req   = bus_read || bus_write;
    assign start = (state == ST_IDLE) && req;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:  if (req) state_nxt = ST_CYCLE;
            ST_CYCLE: if (ack) state_nxt = ST_DONE;   // stb drops with ack
            ST_DONE:  state_nxt = ST_IDLE;
            default:  state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            we    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (start) we <= bus_write; // direction fixed for the whole cycle
        end
    end

    // address and data captured once per access
    always_ff @(posedge clk) begin
        if (start) begin
            adr   <= bus_addr;
            dat_w <= bus_wdata;
        end
        if (state == ST_CYCLE && ack) bus_rdata <= dat_r; // keep for done cycle
    end

    assign cyc      = (state == ST_CYCLE);
    assign stb      = (state == ST_CYCLE);
    assign bus_busy = start || (state == ST_CYCLE); // low only in done or idle

endmodule

// File: hdl/data_memory.sv
`timescale 1ns/1ps

module data_memory #(
    parameter int MEM_DEPTH = 2048 // words
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            cyc,
    input  logic            stb,
    input  logic            we,
    input  mmio_pkg::word_t adr,
    input  mmio_pkg::word_t dat_w,
    output logic            ack,
    output mmio_pkg::word_t dat_r
);
    import mmio_pkg::*;

    localparam int AW = $clog2(MEM_DEPTH);

    word_t         mem [MEM_DEPTH];
    logic [AW-1:0] idx;  // page bits above are ignored
    logic          take; // new strobe, not the tail of an acked one

    assign idx  = adr[AW-1:0];
    assign take = cyc && stb && !ack;

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = init_word(i); // known content for fetch and data reads
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) ack <= 1'b0;
        else         ack <= take; // one cycle pulse, stb still high is ignored
    end

    // array and read port
    always @(posedge clk) begin
        if (take) begin
            if (we) mem[idx] <= dat_w;
            dat_r <= mem[idx];   // old word on a write, nobody looks at it
        end
    end

endmodule

// File: hdl/ext_register_bank.sv
`timescale 1ns/1ps

module ext_register_bank (
    input  logic                clk,
    input  logic                arst_n,
    // outside pins
    input  logic                ext_wr_en,
    input  mmio_pkg::reg_addr_t ext_wr_addr,
    input  mmio_pkg::word_t     ext_wr_data,
    // decoder side
    input  logic                reg_read,
    input  mmio_pkg::reg_addr_t reg_addr,
    output mmio_pkg::word_t     reg_data,
    output logic                reg_ack,
    output logic                chip_sel    // low the cycle after a pin write
);
    import mmio_pkg::*;

    localparam int REG_COUNT = 2 ** $bits(reg_addr_t);

    word_t regs [REG_COUNT];
    logic  serve; // read taken this edge

    // no read while chip select is down, and no back to back acks
    assign serve = reg_read && chip_sel && !reg_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            chip_sel <= 1'b1;
            reg_ack  <= 1'b0;
        end else begin
            if (ext_wr_en) regs[ext_wr_addr] <= ext_wr_data; // pins always win
            chip_sel <= !ext_wr_en;
            reg_ack  <= serve;
        end
    end

    // read data lines up with reg_ack
    always_ff @(posedge clk) begin
        if (serve) reg_data <= regs[reg_addr];
    end

endmodule

// File: hdl/tft_spi_writer.sv
`timescale 1ns/1ps

module tft_spi_writer #(
    parameter int SPI_DIV = 4 // clocks per half sclk period
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            tft_write,
    input  logic [7:0]      tft_addr,
    input  mmio_pkg::word_t tft_data,
    output logic            tft_busy,
    output logic            spi_sclk,
    output logic            spi_mosi,
    output logic            spi_cs_n
);
    import mmio_pkg::*;

    localparam int FRAME_W = 8 + $bits(word_t);               // addr byte + data
    localparam int DIV_W   = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
    localparam int BIT_W   = $clog2(FRAME_W);

    typedef enum logic {
        ST_IDLE,
        ST_SHIFT
    } state_t;

    state_t             state;
    logic [DIV_W-1:0]   div_cnt;
    logic [BIT_W-1:0]   bit_cnt; // bits already shifted out
    logic [FRAME_W-1:0] frame;   // msb is on the wire
    logic               sclk_q;
    logic               tick;    // half period elapsed
    logic               accept;
    logic               fall;    // sclk about to go low

    assign tick   = (div_cnt == DIV_W'(SPI_DIV - 1));
    assign accept = (state == ST_IDLE) && tft_write;
    assign fall   = (state == ST_SHIFT) && tick && sclk_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
        end else if (accept) begin
            state   <= ST_SHIFT; // cs_n drops, first bit already on mosi
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
        end else if (state == ST_SHIFT) begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) sclk_q <= !sclk_q;
            if (fall) begin
                if (bit_cnt == BIT_W'(FRAME_W - 1)) state <= ST_IDLE; // last bit done
                else                                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // mode 0: next bit moves out on the falling edge
    always_ff @(posedge clk) begin
        if (accept)    frame <= {tft_addr, tft_data};
        else if (fall) frame <= {frame[FRAME_W-2:0], 1'b0};
    end

    assign tft_busy = (state == ST_SHIFT);
    assign spi_cs_n = (state == ST_IDLE);
    assign spi_sclk = sclk_q;
    assign spi_mosi = frame[FRAME_W-1];

endmodule

// File: hdl/mmio_subsystem.sv
`timescale 1ns/1ps

module mmio_subsystem #(
    parameter int MEM_DEPTH = 2048, // words in the unified memory
    parameter int SPI_DIV   = 4     // clocks per half sclk period
) (
    input  logic                clk,
    input  logic                arst_n,
    // cpu
    input  mmio_pkg::rwi_t      rwi,
    input  mmio_pkg::word_t     addr,
    input  mmio_pkg::word_t     wdata,
    output logic                busy,
    output mmio_pkg::word_t     rdata,
    output mmio_pkg::word_t     instr,
    // register pins
    input  logic                ext_wr_en,
    input  mmio_pkg::reg_addr_t ext_wr_addr,
    input  mmio_pkg::word_t     ext_wr_data,
    // display
    output logic                spi_sclk,
    output logic                spi_mosi,
    output logic                spi_cs_n
);
    import mmio_pkg::*;

    // decoder <-> bus manager
    logic      bus_read, bus_write, bus_busy;
    word_t     bus_addr, bus_wdata, bus_rdata;
    // bus manager <-> memory
    logic      cyc, stb, we, ack;
    word_t     adr, dat_w, dat_r;
    // decoder <-> register bank
    logic      reg_read, reg_ack, chip_sel;
    reg_addr_t reg_addr;
    word_t     reg_data;
    // decoder <-> spi writer
    logic       tft_write, tft_busy;
    logic [7:0] tft_addr;
    word_t      tft_data;

    mmio_decoder i_mmio_decoder (
        .rwi, .addr, .wdata, .busy, .rdata, .instr,
        .bus_busy, .bus_rdata, .bus_read, .bus_write, .bus_addr, .bus_wdata,
        .reg_data, .reg_ack, .chip_sel, .reg_read, .reg_addr,
        .tft_busy, .tft_write, .tft_addr, .tft_data
    );

    wb_manager i_wb_manager (
        .clk, .arst_n,
        .bus_read, .bus_write, .bus_addr, .bus_wdata, .bus_busy, .bus_rdata,
        .cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r
    );

    data_memory #(.MEM_DEPTH(MEM_DEPTH)) i_data_memory (
        .clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .ack, .dat_r
    );

    ext_register_bank i_ext_register_bank (
        .clk, .arst_n, .ext_wr_en, .ext_wr_addr, .ext_wr_data,
        .reg_read, .reg_addr, .reg_data, .reg_ack, .chip_sel
    );

    tft_spi_writer #(.SPI_DIV(SPI_DIV)) i_tft_spi_writer (
        .clk, .arst_n, .tft_write, .tft_addr, .tft_data,
        .tft_busy, .spi_sclk, .spi_mosi, .spi_cs_n
    );

endmodule

// File: tb/mmio_asserts.sv
`timescale 1ns/1ps

module mmio_asserts (
    input logic clk,
    input logic arst_n,
    input logic busy,
    input logic bus_read,
    input logic bus_write,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic reg_ack
);
    int fail_count = 0; // summed into the testbench error count

    // decoder picks one bus direction per request
    one_bus_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(bus_read && bus_write))
    else begin
        fail_count++;
        $error("bus_read and bus_write high together");
    end

    // memory answers only inside an open strobe of the manager
    ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> (cyc && stb))
    else begin
        fail_count++;
        $error("ack outside an open bus cycle");
    end

    // bank never acks back to back
    single_reg_ack: assert property (@(posedge clk) disable iff (!arst_n)
        reg_ack |=> !reg_ack)
    else begin
        fail_count++;
        $error("reg_ack held for two cycles");
    end

    quiet_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> !busy)
    else begin
        fail_count++;
        $error("busy high right after reset release");
    end

endmodule

bind mmio_subsystem mmio_asserts i_mmio_asserts (
    .clk, .arst_n, .busy, .bus_read, .bus_write, .cyc, .stb, .ack, .reg_ack
);

// File: tb/tb_mmio_subsystem.sv
`timescale 1ns/1ps

module tb_mmio_subsystem;
    import mmio_pkg::*;

    localparam int MEM_DEPTH   = 2048;
    localparam int SPI_DIV     = 4;
    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 8;
    localparam int NUM_REQ     = 240;
    localparam int FRAME_W     = 40;                          // addr byte then data word
    localparam int FRAME_CLKS  = FRAME_W * 2 * SPI_DIV + 4;   // worst shift time of a frame
    // every request may sit behind a full frame, plus the final drain
    localparam int CYCLE_LIMIT = RST_CYCLES + 16 + NUM_REQ * (FRAME_CLKS + 16) + 2 * FRAME_CLKS;

    logic      clk = 1'b0;
    logic      arst_n;
    rwi_t      rwi;
    word_t     addr;
    word_t     wdata;
    logic      busy;
    word_t     rdata;
    word_t     instr;
    logic      ext_wr_en;
    reg_addr_t ext_wr_addr;
    word_t     ext_wr_data;
    logic      spi_sclk;
    logic      spi_mosi;
    logic      spi_cs_n;

    // reference model
    word_t              mem_m [MEM_DEPTH];
    word_t              regs_m [32];
    logic [FRAME_W-1:0] exp_frames [$];  // frames the writer still owes, oldest first

    int unsigned        rand_state = 25553;
    int                 n_checks = 0;
    int                 n_errors = 0;
    int                 n_frames = 0;
    int                 n_held   = 0;    // tft writes held back by a busy writer
    int                 cycles   = 0;
    int                 cap_bits = 0;    // bits of the frame on the wire so far
    logic [FRAME_W-1:0] cap_frame = '0;

    mmio_subsystem #(.MEM_DEPTH(MEM_DEPTH), .SPI_DIV(SPI_DIV)) i_mmio_subsystem (
        .clk, .arst_n, .rwi, .addr, .wdata, .busy, .rdata, .instr,
        .ext_wr_en, .ext_wr_addr, .ext_wr_data, .spi_sclk, .spi_mosi, .spi_cs_n
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles, DUT stopped answering", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic int unsigned next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state >> 8;  // low bits of an lcg repeat too fast
    endfunction

    // full 32 bit value from two draws, one draw only carries 24 bits
    function automatic word_t rand_word();
        word_t hi;
        hi = next_rand();
        return (hi << 16) ^ next_rand();
    endfunction

    // word i of a memory nobody wrote yet
    function automatic word_t fresh_word(input int unsigned i);
        return i * 32'h0101_0101;
    endfunction

    function automatic word_t pick_data_addr();
        if (next_rand() % 4 != 0) return REG_TOP + 1 + next_rand() % 24; // hot window, reuse
        return REG_TOP + 1 + next_rand() % (DMEM_TOP - REG_TOP);
    endfunction

    function automatic word_t pick_fetch_addr();
        return next_rand() % (FETCH_TOP + 1);
    endfunction

    function automatic word_t pick_tft_addr();
        return DMEM_TOP + 1 + next_rand() % (TFT_TOP - DMEM_TOP);
    endfunction

    task automatic flag_error(input string msg);
        n_errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    task automatic expect_word(input string what, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            flag_error($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic apply_reset();
        word_t a;
        word_t d;
        a = TFT_TOP;
        d = rand_word();
        arst_n      <= 1'b0;
        rwi         <= RWI_WRITE;    // tft write held across release
        addr        <= a;
        wdata       <= d;
        ext_wr_en   <= 1'b0;
        ext_wr_addr <= '0;
        ext_wr_data <= '0;
        exp_frames.push_back({a[7:0], d});
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);              // writer comes up free, write taken on this edge
        rwi <= RWI_IDLE;
        @(posedge clk);
        @(negedge clk);
    endtask

    // drive one request, return at the negedge before the completing edge
    task automatic cpu_access(input rwi_t code, input word_t a, input word_t d,
                              output int waited);
        @(posedge clk);
        rwi       <= code;
        addr      <= a;
        wdata     <= d;
        ext_wr_en <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            waited++;                  // held, the global counter bounds this
            @(negedge clk);
        end
    endtask

    task automatic pin_write(input reg_addr_t idx, input word_t val);
        @(posedge clk);
        rwi         <= RWI_IDLE;
        ext_wr_en   <= 1'b1;
        ext_wr_addr <= idx;
        ext_wr_data <= val;
        regs_m[idx] = val;             // lands on the next edge, before any later read
        @(negedge clk);
    endtask

    task automatic do_fetch(input word_t a);
        int waited;
        cpu_access(RWI_FETCH, a, next_rand(), waited);
        expect_word($sformatf("instr at %0d", a), instr, mem_m[a[10:0]]);
    endtask

    task automatic do_data_write(input word_t a, input word_t d);
        int waited;
        cpu_access(RWI_WRITE, a, d, waited);
        mem_m[a[10:0]] = d;
    endtask

    task automatic do_data_read(input word_t a);
        int waited;
        cpu_access(RWI_READ, a, next_rand(), waited);
        expect_word($sformatf("rdata at %0d", a), rdata, mem_m[a[10:0]]);
    endtask

    task automatic do_reg_read(input reg_addr_t idx);
        word_t a;
        int    waited;
        a = (idx == '0) ? REG_TOP : FETCH_TOP + idx; // register index is addr[4:0]
        cpu_access(RWI_READ, a, next_rand(), waited);
        expect_word($sformatf("register %0d", idx), rdata, regs_m[idx]);
    endtask

    task automatic do_tft_write(input word_t a, input word_t d);
        int waited;
        cpu_access(RWI_WRITE, a, d, waited);
        if (waited > 0) n_held++;
        exp_frames.push_back({a[7:0], d});
    endtask

    // tft reads, register writes and instruction writes fall through
    task automatic do_ignored(input rwi_t code, input word_t a, input word_t d);
        int waited;
        cpu_access(code, a, d, waited);
        n_checks++;
        if (waited != 0) begin
            flag_error($sformatf("ignored access at %0d held busy %0d cycles", a, waited));
        end
        expect_word($sformatf("rdata of ignored access at %0d", a), rdata, '0);
    endtask

    task automatic take_frame(input logic [FRAME_W-1:0] got);
        logic [FRAME_W-1:0] exp;
        n_frames++;
        n_checks++;
        if (exp_frames.size() == 0) begin
            n_errors++;
            $display("spi frame %h arrived with no tft write pending", got);
        end else begin
            exp = exp_frames.pop_front();
            if (got !== exp) flag_error($sformatf("spi frame %h, expected %h", got, exp));
        end
    endtask

    task automatic finish_spi();
        @(posedge clk);
        rwi       <= RWI_IDLE;
        ext_wr_en <= 1'b0;
        while (exp_frames.size() != 0 || !spi_cs_n) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
    endtask

    // mode 0, mosi is stable on the rising sclk
    always @(posedge spi_sclk) begin
        if (!spi_cs_n) begin
            cap_frame = {cap_frame[FRAME_W-2:0], spi_mosi};
            cap_bits++;
            if (cap_bits == FRAME_W) begin
                take_frame(cap_frame);
                cap_bits = 0;
            end
        end
    end

    always @(posedge spi_cs_n) begin
        if (cap_bits != 0) begin
            n_errors++;
            $display("spi frame cut short after %0d bits", cap_bits);
            cap_bits = 0;
        end
    end

    initial begin
        int unsigned kind;
        reg_addr_t   idx;
        word_t       val;

        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem_m[i] = fresh_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        apply_reset();

        for (int n = 0; n < NUM_REQ; n++) begin
            if (next_rand() % 5 == 0) begin
                idx = reg_addr_t'(next_rand());
                val = rand_word();
                pin_write(idx, val);
                if (next_rand() % 2 == 0) do_reg_read(idx); // lands while chip_sel is low
            end
            kind = next_rand() % 16;
            case (kind)
                0, 1, 2:  do_fetch(pick_fetch_addr());
                3, 4, 5:  do_data_write(pick_data_addr(), rand_word());
                6, 7, 8:  do_data_read(pick_data_addr());
                9, 10:    do_reg_read(reg_addr_t'(next_rand()));
                11, 12:   do_tft_write(pick_tft_addr(), rand_word());
                13:       do_ignored(RWI_READ, pick_tft_addr(), next_rand());
                14:       do_ignored(RWI_WRITE, FETCH_TOP + 1 + next_rand() % 32, next_rand());
                default:  do_ignored(RWI_WRITE, pick_fetch_addr(), next_rand());
            endcase
        end
        finish_spi();

        if (n_held == 0) begin
            n_errors++;
            $display("no tft write ever had to wait for a busy writer");
        end
        if (i_mmio_subsystem.i_mmio_asserts.fail_count != 0) begin
            n_errors += i_mmio_subsystem.i_mmio_asserts.fail_count;
            $display("%0d concurrent assertion failures",
                     i_mmio_subsystem.i_mmio_asserts.fail_count);
        end
        $display("checks %0d  frames %0d  held tft writes %0d  errors %0d",
                 n_checks, n_frames, n_held, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
hdl/mmio_pkg.sv
hdl/mmio_decoder.sv
hdl/wb_manager.sv
hdl/data_memory.sv
hdl/ext_register_bank.sv
hdl/tft_spi_writer.sv
hdl/mmio_subsystem.sv
tb/mmio_asserts.sv
tb/tb_mmio_subsystem.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mmio_subsystem \
    -f all.f

out=$(./obj_dir/Vtb_mmio_subsystem 2>&1) || true
printf '%s\n' "$out"

# verdict comes from the pass line alone
printf '%s\n' "$out" | grep -qx '>>> PASS'
